// ==== verilog/fp_pkg.sv ====
package fp_pkg;

  localparam int FP_WIDTH = 24;
  localparam int FRAC_BITS = 16;

  // Q8.16 signed fixed point
  typedef logic signed [FP_WIDTH-1:0] fp;

  typedef struct packed {
    fp x;
    fp y;
    fp z;
  } vec3;

  localparam fp FP_ZERO = 24'sd0;
  localparam fp FP_ONE = 24'sd65536;
  localparam fp FP_THREE_HALFS = 24'sd98304;

  // cos and sin of 0.01 rad
  localparam fp FP_COS_STEP = 24'sd65533;
  localparam fp FP_SIN_STEP = 24'sd655;

  // Pan step is FP_ONE >> STEP_SHIFT
  localparam int STEP_SHIFT = 7;

  function automatic fp fp_add(fp a, fp b);
    return a + b;
  endfunction

  function automatic fp fp_sub(fp a, fp b);
    return a - b;
  endfunction

  function automatic fp fp_neg(fp a);
    return ~a + 24'sd1;
  endfunction

  function automatic fp fp_mul(fp a, fp b);
    logic signed [2*FP_WIDTH-1:0] prod;
    prod = a * b;
    // Drop fraction bits, keep low word
    return fp'(prod >>> FRAC_BITS);
  endfunction

endpackage

// ==== verilog/control_pkg.sv ====
package control_pkg;

  typedef enum logic [1:0] {
    MODE_WALK   = 2'd0,
    MODE_PAN_XY = 2'd1,
    MODE_PAN_XZ = 2'd2,
    MODE_HOLD   = 2'd3
  } ctrl_mode_e;

  typedef struct packed {
    logic left;
    logic right;
    logic up;
    logic down;
  } buttons_t;

  typedef struct packed {
    logic [2:0] fractal_sel;
    logic       hue_en;
    logic       color_en;
    logic       checker_en;
    logic       dither_en;
  } render_settings_t;

  // Switch word layout
  localparam int SW_WIDTH = 16;
  localparam int SW_MODE_LSB = 0;
  localparam int SW_SPEED_LSB = 2;
  localparam int SW_HUE = 4;
  localparam int SW_COLOR = 5;
  localparam int SW_DITHER = 11;
  localparam int SW_CHECKER = 12;
  localparam int SW_FRACTAL_LSB = 13;

endpackage

// ==== verilog/input_sync.sv ====
module input_sync (
  input  logic                          clk_in,
  input  logic                          rst_in,
  input  control_pkg::buttons_t         btn_raw,
  input  logic [15:0]                   sw,
  output control_pkg::buttons_t         btn,
  output control_pkg::ctrl_mode_e       mode,
  output logic [1:0]                    speed,
  output control_pkg::render_settings_t settings
);
  import control_pkg::*;

  buttons_t btn_meta;
  buttons_t btn_sync;
  logic [SW_WIDTH-1:0] sw_meta;
  logic [SW_WIDTH-1:0] sw_sync;

  // Two flop stages against metastability
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      btn_meta <= '0;
      btn_sync <= '0;
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      btn_meta <= btn_raw;
      btn_sync <= btn_meta;
      sw_meta <= sw;
      sw_sync <= sw_meta;
    end
  end

  assign btn = btn_sync;

  // Field decode of the synchronized switch word
  assign mode = ctrl_mode_e'(sw_sync[SW_MODE_LSB +: 2]);
  assign speed = sw_sync[SW_SPEED_LSB +: 2];

  assign settings = '{
    fractal_sel: sw_sync[SW_FRACTAL_LSB +: 3],
    hue_en:      sw_sync[SW_HUE],
    color_en:    sw_sync[SW_COLOR],
    checker_en:  sw_sync[SW_CHECKER],
    dither_en:   sw_sync[SW_DITHER]
  };

endmodule

// ==== verilog/step_timer.sv ====
module step_timer #(
  parameter int TICK_CYCLES = 50000
) (
  input  logic       clk_in,
  input  logic       rst_in,
  input  logic [1:0] speed,
  output logic       step
);

  // Sized for the slowest period, 4 * TICK_CYCLES
  localparam int CNT_W = $clog2(4 * TICK_CYCLES);

  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] limit;

  // Last count of the current period
  assign limit = CNT_W'((int'(speed) + 1) * TICK_CYCLES - 1);
  assign step = (count == limit);

  // Past the limit after a speed change it runs on to the natural wrap
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      count <= '0;
    end else if (step) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

// ==== verilog/camera_pose.sv ====
module camera_pose (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    step,
  input  control_pkg::ctrl_mode_e mode,
  input  control_pkg::buttons_t   btn,
  output fp_pkg::vec3             pos,
  output fp_pkg::vec3             dir,
  output logic                    pose_update
);
  import fp_pkg::*;
  import control_pkg::*;

  localparam fp PAN_STEP = fp'(FP_ONE >>> STEP_SHIFT);

  vec3 pos_next;
  vec3 dir_next;
  fp walk_dx;
  fp walk_dz;
  fp rot_s;

  // Move one axis down on dec, up on inc, hold when both or neither
  function automatic fp axis_move(fp value, logic dec, logic inc, fp delta);
    if (dec && !inc) begin
      return fp_sub(value, delta);
    end
    if (inc && !dec) begin
      return fp_add(value, delta);
    end
    return value;
  endfunction

  // Forward step is the view direction scaled down
  assign walk_dx = dir.x >>> STEP_SHIFT;
  assign walk_dz = dir.z >>> STEP_SHIFT;

  // Left turn wins when both are held
  assign rot_s = btn.left ? fp_neg(FP_SIN_STEP) : FP_SIN_STEP;

  always_comb begin
    pos_next = pos;
    dir_next = dir;
    case (mode)
      MODE_PAN_XY: begin
        pos_next.x = axis_move(pos.x, btn.left, btn.right, PAN_STEP);
        pos_next.y = axis_move(pos.y, btn.down, btn.up, PAN_STEP);
      end
      MODE_PAN_XZ: begin
        pos_next.x = axis_move(pos.x, btn.left, btn.right, PAN_STEP);
        pos_next.z = axis_move(pos.z, btn.down, btn.up, PAN_STEP);
      end
      MODE_WALK: begin
        pos_next.x = axis_move(pos.x, btn.down, btn.up, walk_dx);
        pos_next.z = axis_move(pos.z, btn.down, btn.up, walk_dz);
        // Yaw rotation in the XZ plane, old direction on both rows
        if (btn.left || btn.right) begin
          dir_next.x = fp_add(fp_mul(dir.x, FP_COS_STEP), fp_mul(dir.z, rot_s));
          dir_next.z = fp_sub(fp_mul(dir.z, FP_COS_STEP), fp_mul(dir.x, rot_s));
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pos.x <= FP_ZERO;
      pos.y <= FP_ONE;
      pos.z <= fp_neg(FP_THREE_HALFS);
      dir.x <= FP_ZERO;
      dir.y <= FP_ZERO;
      dir.z <= FP_ONE;
      pose_update <= 1'b0;
    end else begin
      if (step) begin
        pos <= pos_next;
        dir <= dir_next;
      end
      // High in the cycle the new pose appears
      pose_update <= step && (mode != MODE_HOLD);
    end
  end

endmodule

// ==== verilog/camera_control_top.sv ====
module camera_control_top #(
  parameter int TICK_CYCLES = 50000
) (
  input  logic                          clk_in,
  input  logic                          rst_in,
  input  logic                          btnl,
  input  logic                          btnr,
  input  logic                          btnu,
  input  logic                          btnd,
  input  logic [15:0]                   sw,
  output fp_pkg::vec3                   pos_out,
  output fp_pkg::vec3                   dir_out,
  output control_pkg::render_settings_t settings_out,
  output logic                          pose_update_out
);
  import control_pkg::*;

  buttons_t btn_raw;
  buttons_t btn;
  ctrl_mode_e mode;
  logic [1:0] speed;
  logic step;

  assign btn_raw = '{left: btnl, right: btnr, up: btnu, down: btnd};

  input_sync i_input_sync (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .btn_raw  (btn_raw),
    .sw       (sw),
    .btn      (btn),
    .mode     (mode),
    .speed    (speed),
    .settings (settings_out)
  );

  // Step rate follows the speed switches
  step_timer #(
    .TICK_CYCLES (TICK_CYCLES)
  ) i_step_timer (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .speed  (speed),
    .step   (step)
  );

  camera_pose i_camera_pose (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .step        (step),
    .mode        (mode),
    .btn         (btn),
    .pos         (pos_out),
    .dir         (dir_out),
    .pose_update (pose_update_out)
  );

endmodule

// ==== tests/camera_control_properties.sv ====
module camera_control_properties (
  input logic        clk_in,
  input logic        rst_in,
  input logic        step,
  input logic        pose_update,
  input fp_pkg::vec3 pos,
  input fp_pkg::vec3 dir
);
  timeunit 1ns;
  timeprecision 1ps;
  import fp_pkg::*;

  // Steps are at least TICK_CYCLES apart
  a_single_update: assert property (@(posedge clk_in) disable iff (rst_in)
    pose_update |=> !pose_update)
    else $error("pose_update high for two cycles");

  a_pose_on_step: assert property (@(posedge clk_in) disable iff (rst_in)
    !step |=> ($stable(pos) && $stable(dir)))
    else $error("pose changed without a step");

  // Yaw only, so no vertical view component
  a_dir_y_zero: assert property (@(posedge clk_in) disable iff (rst_in)
    dir.y == FP_ZERO)
    else $error("dir.y is not zero");

endmodule

bind camera_pose camera_control_properties i_camera_control_properties (
  .clk_in      (clk_in),
  .rst_in      (rst_in),
  .step        (step),
  .pose_update (pose_update),
  .pos         (pos),
  .dir         (dir)
);

// ==== tests/camera_control_tb.sv ====
module camera_control_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fp_pkg::*;
  import control_pkg::*;

  localparam int TICKS = 8;
  localparam int VEC_CYCLES = 96;
  localparam int PAN_VECS = 8;
  localparam int WALK_VECS = 16;
  localparam int SET_VECS = 16;
  localparam int SETTLE = 40;
  localparam int RUN_CYCLES = 8 + (2 * PAN_VECS + WALK_VECS) * (VEC_CYCLES + 1)
    + (5 + VEC_CYCLES) + SET_VECS * 4 + 4 * (1 + SETTLE + VEC_CYCLES);
  localparam int MAX_CYCLES = RUN_CYCLES + RUN_CYCLES / 5;

  typedef struct packed {
    vec3 pos;
    vec3 dir;
  } pose_t;

  logic clk_in;
  logic rst_in;
  logic btnl;
  logic btnr;
  logic btnu;
  logic btnd;
  logic [15:0] sw;
  vec3 pos_out;
  vec3 dir_out;
  render_settings_t settings_out;
  logic pose_update_out;

  logic [31:0] lfsr_state;
  logic [15:0] sw_d1;
  logic [15:0] sw_d2;
  logic [15:0] sw_d3;
  buttons_t btn_d1;
  buttons_t btn_d2;
  buttons_t btn_d3;
  pose_t expected;
  int update_count = 0;
  int check_count = 0;
  int error_count = 0;
  int cycle_count = 0;

  camera_control_top #(
    .TICK_CYCLES (TICKS)
  ) i_camera_control_top (
    .clk_in          (clk_in),
    .rst_in          (rst_in),
    .btnl            (btnl),
    .btnr            (btnr),
    .btnu            (btnu),
    .btnd            (btnd),
    .sw              (sw),
    .pos_out         (pos_out),
    .dir_out         (dir_out),
    .settings_out    (settings_out),
    .pose_update_out (pose_update_out)
  );

  always #50 clk_in = ~clk_in;

  always @(posedge clk_in) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  // Two sync stages, then one more for the inputs seen at the step edge
  always @(posedge clk_in) begin
    if (rst_in) begin
      sw_d1 <= '0;
      sw_d2 <= '0;
      sw_d3 <= '0;
      btn_d1 <= '0;
      btn_d2 <= '0;
      btn_d3 <= '0;
    end else begin
      sw_d1 <= sw;
      sw_d2 <= sw_d1;
      sw_d3 <= sw_d2;
      btn_d1 <= '{left: btnl, right: btnr, up: btnu, down: btnd};
      btn_d2 <= btn_d1;
      btn_d3 <= btn_d2;
    end
  end

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return bits;
  endfunction

  function automatic fp ref_mul(input fp a, input fp b);
    logic signed [47:0] p;
    p = $signed({{24{a[23]}}, a}) * $signed({{24{b[23]}}, b});
    return p[39:16];
  endfunction

  function automatic fp shr7(input fp a);
    return {{7{a[23]}}, a[23:7]};
  endfunction

  function automatic fp axis_step(input fp value, input int sgn, input fp delta);
    if (sgn > 0) begin
      return value + delta;
    end else if (sgn < 0) begin
      return value - delta;
    end
    return value;
  endfunction

  function automatic pose_t next_pose(input vec3 pos, input vec3 dir, input ctrl_mode_e mode,
                                      input buttons_t b);
    pose_t nxt;
    int h;
    int v;
    fp s;
    nxt.pos = pos;
    nxt.dir = dir;
    h = 0;
    v = 0;
    if (b.right && !b.left) h = 1;
    if (b.left && !b.right) h = -1;
    if (b.up && !b.down) v = 1;
    if (b.down && !b.up) v = -1;
    case (mode)
      MODE_PAN_XY: begin
        nxt.pos.x = axis_step(pos.x, h, 24'sd512);
        nxt.pos.y = axis_step(pos.y, v, 24'sd512);
      end
      MODE_PAN_XZ: begin
        nxt.pos.x = axis_step(pos.x, h, 24'sd512);
        nxt.pos.z = axis_step(pos.z, v, 24'sd512);
      end
      MODE_WALK: begin
        nxt.pos.x = axis_step(pos.x, v, shr7(dir.x));
        nxt.pos.z = axis_step(pos.z, v, shr7(dir.z));
        if (b.left || b.right) begin
          s = b.left ? -24'sd655 : 24'sd655;
          nxt.dir.x = ref_mul(dir.x, 24'sd65533) + ref_mul(dir.z, s);
          nxt.dir.z = ref_mul(dir.z, 24'sd65533) - ref_mul(dir.x, s);
        end
      end
      default: begin
      end
    endcase
    return nxt;
  endfunction

  task automatic check_vec3(input string name, input vec3 got, input vec3 exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_settings(input string name, input render_settings_t got,
                                input render_settings_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Every pose update against the prediction from the previous pose
  task automatic compare_updates();
    forever begin
      @(negedge clk_in);
      if (pose_update_out) begin
        expected = next_pose(expected.pos, expected.dir, ctrl_mode_e'(sw_d3[1:0]), btn_d3);
        check_vec3("pos_out", pos_out, expected.pos);
        check_vec3("dir_out", dir_out, expected.dir);
        update_count++;
      end
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_in);
  endtask

  task automatic count_updates(input int n, output int cnt);
    cnt = 0;
    repeat (n) begin
      @(negedge clk_in);
      if (pose_update_out) cnt++;
    end
  endtask

  task automatic drive_random(input logic [1:0] mode);
    logic [31:0] r;
    logic [3:0] b;
    logic [15:0] s;
    r = rand_bits(4);
    b = r[3:0];
    r = rand_bits(14);
    s = {r[13:0], mode};
    @(negedge clk_in);
    btnl = b[3];
    btnr = b[2];
    btnu = b[1];
    btnd = b[0];
    sw = s;
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%-22s finished, %0d errors", name, error_count - errors_before);
  endtask

  task automatic reset_values();
    int errors_before;
    vec3 exp_pos;
    vec3 exp_dir;
    errors_before = error_count;
    exp_pos.x = 24'sd0;
    exp_pos.y = 24'sd65536;
    exp_pos.z = -24'sd98304;
    exp_dir.x = 24'sd0;
    exp_dir.y = 24'sd0;
    exp_dir.z = 24'sd65536;
    check_vec3("pos_out", pos_out, exp_pos);
    check_vec3("dir_out", dir_out, exp_dir);
    check_settings("settings_out", settings_out, '0);
    check_bit("pose_update_out", pose_update_out, 1'b0);
    report_test("reset state", errors_before);
  endtask

  task automatic random_moves(input string name, input logic [1:0] mode, input int vecs);
    int errors_before;
    int updates_before;
    errors_before = error_count;
    updates_before = update_count;
    for (int i = 0; i < vecs; i++) begin
      drive_random(mode);
      wait_cycles(VEC_CYCLES);
    end
    if (update_count == updates_before) begin
      error_count++;
      $display("%s gave no pose updates at all", name);
    end
    report_test(name, errors_before);
  endtask

  task automatic hold_mode();
    int errors_before;
    int cnt;
    vec3 held_pos;
    vec3 held_dir;
    errors_before = error_count;
    drive_random(2'd3);
    // Let a step taken with the old mode drain
    wait_cycles(4);
    held_pos = pos_out;
    held_dir = dir_out;
    count_updates(VEC_CYCLES, cnt);
    if (cnt != 0) begin
      error_count++;
      $display("Hold mode still gave %0d pose updates", cnt);
    end
    check_vec3("pos_out", pos_out, held_pos);
    check_vec3("dir_out", dir_out, held_dir);
    report_test("hold mode", errors_before);
  endtask

  task automatic settings_passthrough();
    int errors_before;
    logic [31:0] r;
    logic [15:0] s;
    render_settings_t exp;
    errors_before = error_count;
    for (int i = 0; i < SET_VECS; i++) begin
      r = rand_bits(16);
      s = r[15:0];
      @(negedge clk_in);
      sw = s;
      wait_cycles(3);
      exp.fractal_sel = s[15:13];
      exp.hue_en = s[4];
      exp.color_en = s[5];
      exp.checker_en = s[12];
      exp.dither_en = s[11];
      check_settings("settings_out", settings_out, exp);
    end
    report_test("settings pass-through", errors_before);
  endtask

  task automatic speed_scaling();
    int errors_before;
    int cnt;
    int expected_cnt;
    errors_before = error_count;
    for (int spd = 0; spd < 4; spd++) begin
      @(negedge clk_in);
      btnl = 1'b0;
      btnr = 1'b1;
      btnu = 1'b0;
      btnd = 1'b0;
      sw = {12'h000, 2'(spd), 2'd1};
      // Old count may sit past the new limit and run to the wrap
      wait_cycles(SETTLE);
      count_updates(VEC_CYCLES, cnt);
      expected_cnt = VEC_CYCLES / ((spd + 1) * TICKS);
      if (cnt < expected_cnt - 1 || cnt > expected_cnt + 1) begin
        error_count++;
        $display("Speed %0d gave %0d pose updates in %0d cycles instead of about %0d",
                 spd, cnt, VEC_CYCLES, expected_cnt);
      end
    end
    report_test("speed scaling", errors_before);
  endtask

  initial begin
    clk_in = 1'b0;
    rst_in = 1'b1;
    btnl = 1'b0;
    btnr = 1'b0;
    btnu = 1'b0;
    btnd = 1'b0;
    sw = '0;
    lfsr_state = 32'hd9d5;
    expected.pos.x = 24'sd0;
    expected.pos.y = 24'sd65536;
    expected.pos.z = -24'sd98304;
    expected.dir.x = 24'sd0;
    expected.dir.y = 24'sd0;
    expected.dir.z = 24'sd65536;
    repeat (8) @(negedge clk_in);
    rst_in = 1'b0;
    fork
      compare_updates();
    join_none
    reset_values();
    random_moves("pan modes XY", 2'd1, PAN_VECS);
    random_moves("pan modes XZ", 2'd2, PAN_VECS);
    random_moves("walk mode", 2'd0, WALK_VECS);
    hold_mode();
    settings_passthrough();
    speed_scaling();
    $display("Tests run: 7, checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
verilog/fp_pkg.sv
verilog/control_pkg.sv
verilog/input_sync.sv
verilog/step_timer.sv
verilog/camera_pose.sv
verilog/camera_control_top.sv
tests/camera_control_properties.sv
tests/camera_control_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the camera control testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module camera_control_tb -o camera_control_sim \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/camera_control_sim > sim.log 2>&1
cat sim.log
grep -qx "Everything OK" sim.log && exit 0 || exit 1
